/* Bender.yml */
package:
  name: branch_unit

sources:
  - include_dirs:
      - src
    files:
      - src/isa_pkg.sv
      - src/core_pkg.sv
      - src/spec_stage.sv
      - src/branch_target_adder.sv
      - src/branch_fu.sv
      - src/branch_tag_tracker.sv
      - src/branch_unit_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/tb_branch_unit.sv

/* sim.f */
+incdir+src
src/isa_pkg.sv
src/core_pkg.sv
src/spec_stage.sv
src/branch_target_adder.sv
src/branch_fu.sv
src/branch_tag_tracker.sv
src/branch_unit_top.sv
testbench/tb_branch_unit.sv

/* src/branch_fu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module branch_fu (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  in_valid,
    input  core_pkg::issue_packet_t is_pack,
    output logic                  result_valid,
    output core_pkg::fu_packet_t  result,
    output core_pkg::br_resolve_t resolve
);
    import core_pkg::*;
    import isa_pkg::*;

    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] link;
    logic             cond_taken;
    logic             uncond;
    logic             taken;
    logic             correct;
    fu_packet_t       fu_pack;
    fu_packet_t       res_data;
    br_mask_t         res_mask;

    branch_target_adder u_target (
        .pc        (is_pack.pc),
        .rs1_value (is_pack.rs1_value),
        .inst      (is_pack.inst),
        .target    (target)
    );

    always_comb begin
        case (is_pack.inst.b.funct3)
            BEQ:     cond_taken = is_pack.rs1_value == is_pack.rs2_value;
            BNE:     cond_taken = is_pack.rs1_value != is_pack.rs2_value;
            BLT:     cond_taken = $signed(is_pack.rs1_value) <  $signed(is_pack.rs2_value);
            BGE:     cond_taken = $signed(is_pack.rs1_value) >= $signed(is_pack.rs2_value);
            BLTU:    cond_taken = is_pack.rs1_value <  is_pack.rs2_value;
            BGEU:    cond_taken = is_pack.rs1_value >= is_pack.rs2_value;
            default: cond_taken = 1'b0;
        endcase
    end

    assign uncond = (is_pack.inst.b.opcode == OP_JAL) || (is_pack.inst.b.opcode == OP_JALR);
    assign taken  = uncond || ((is_pack.inst.b.opcode == OP_BRANCH) && cond_taken);
    assign link   = is_pack.pc + `XLEN'd4;

    // Direction must match, target too when taken
    assign correct = (is_pack.pred_taken == taken) && (!taken || target == is_pack.pred_target);

    assign fu_pack = '{
        next_pc:      taken ? target : link,
        link:         link,
        rd:           is_pack.rd,
        taken:        taken,
        pred_correct: correct,
        b_id:         is_pack.b_id,
        b_mask:       is_pack.b_mask
    };

    spec_stage #(
        .payload_t (fu_packet_t)
    ) u_result_stage (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (),
        .in_data   (fu_pack),
        .in_mask   (is_pack.b_mask),
        .resolve   (resolve),
        .out_valid (result_valid),
        .out_data  (res_data),
        .out_mask  (res_mask)
    );

    always_comb begin
        result        = res_data;
        result.b_mask = res_mask;  // Stage mask has later clears applied
    end

    always_comb begin
        resolve.id      = result_valid ? res_data.b_id : '0;
        resolve.br_task = NOTHING;
        if (result_valid) begin
            resolve.br_task = res_data.pred_correct ? CLEAR : SQUASH;
        end
    end

    a_resolve_onehot: assert property (@(posedge clock) disable iff (!arst_n)
        resolve.br_task != NOTHING |-> $onehot(resolve.id))
        else $error("branch_fu: resolve id is not one-hot");

endmodule

`default_nettype wire

/* src/branch_tag_tracker.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module branch_tag_tracker (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  alloc_valid,
    output logic                  alloc_ready,
    output core_pkg::br_mask_t    alloc_id,
    output core_pkg::br_mask_t    alloc_mask,
    input  core_pkg::br_resolve_t resolve,
    output core_pkg::br_mask_t    live_mask
);
    import core_pkg::*;

    br_mask_t live_q;
    br_mask_t dep_q [`BR_TAGS];
    br_mask_t free_tags;
    br_mask_t clr_bits;
    br_mask_t dependents;
    br_mask_t free_bits;
    logic     alloc_fire;
    logic     alloc_keep;

    assign free_tags   = ~live_q;
    assign alloc_ready = |free_tags;
    assign alloc_id    = free_tags & (~free_tags + 1'b1);  // Lowest free tag

    assign clr_bits   = (resolve.br_task == CLEAR) ? resolve.id : '0;
    assign alloc_mask = live_q & ~clr_bits;
    assign alloc_fire = alloc_valid && alloc_ready;

    always_comb begin
        dependents = '0;
        for (int t = 0; t < `BR_TAGS; t++) begin
            if (live_q[t] && ((dep_q[t] & resolve.id) != '0)) begin
                dependents[t] = 1'b1;
            end
        end
    end

    always_comb begin
        case (resolve.br_task)
            CLEAR:   free_bits = resolve.id;
            SQUASH:  free_bits = resolve.id | dependents;
            default: free_bits = '0;
        endcase
    end

    // A branch allocated under a squashing one dies with it
    assign alloc_keep = alloc_fire &&
                        !((resolve.br_task == SQUASH) && ((alloc_mask & resolve.id) != '0));

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            live_q <= '0;
        end else begin
            live_q <= (live_q & ~free_bits) | (alloc_keep ? alloc_id : '0);
        end
    end

    always_ff @(posedge clock) begin
        for (int t = 0; t < `BR_TAGS; t++) begin
            if (alloc_keep && alloc_id[t]) begin
                dep_q[t] <= alloc_mask;
            end else begin
                dep_q[t] <= dep_q[t] & ~free_bits;
            end
        end
    end

    assign live_mask = live_q;

    a_resolve_live: assert property (@(posedge clock) disable iff (!arst_n)
        resolve.br_task != NOTHING |-> (resolve.id & ~live_q) == '0)
        else $error("branch_tag_tracker: resolved tag is not live");

endmodule

`default_nettype wire

/* src/branch_target_adder.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module branch_target_adder (
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_value,
    input  isa_pkg::inst_t   inst,
    output logic [`XLEN-1:0] target
);
    import isa_pkg::*;

    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] base;
    logic [`XLEN-1:0] sum;
    logic             is_jalr;

    assign imm_b = {{(`XLEN-12){inst.b.imm12}}, inst.b.imm11, inst.b.imm10_5,
                    inst.b.imm4_1, 1'b0};
    assign imm_j = {{(`XLEN-20){inst.j.imm20}}, inst.j.imm19_12, inst.j.imm11,
                    inst.j.imm10_1, 1'b0};
    assign imm_i = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};

    assign is_jalr = (inst.i.opcode == OP_JALR);

    always_comb begin
        case (inst.b.opcode)
            OP_JAL:  imm = imm_j;
            OP_JALR: imm = imm_i;
            default: imm = imm_b;
        endcase
    end

    assign base = is_jalr ? rs1_value : pc;  // JALR is register relative
    assign sum  = base + imm;

    assign target = is_jalr ? {sum[`XLEN-1:1], 1'b0} : sum;

endmodule

`default_nettype wire

/* src/branch_unit_top.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_unit_top (
    input  logic                    clock,
    input  logic                    arst_n,
    input  logic                    issue_valid,
    output logic                    issue_ready,
    input  core_pkg::issue_packet_t issue_pack,
    input  logic                    alloc_valid,
    output logic                    alloc_ready,
    output core_pkg::br_mask_t      alloc_id,
    output core_pkg::br_mask_t      alloc_mask,
    output core_pkg::br_mask_t      live_mask,
    output logic                    result_valid,
    output core_pkg::fu_packet_t    result,
    output core_pkg::br_resolve_t   resolve
);
    import core_pkg::*;

    logic          iss_valid;
    issue_packet_t iss_data;
    br_mask_t      iss_mask;
    issue_packet_t fu_in;

    spec_stage #(
        .payload_t (issue_packet_t)
    ) u_issue_stage (
        .clock     (clock),
        .arst_n    (arst_n),
        .in_valid  (issue_valid),
        .in_ready  (issue_ready),
        .in_data   (issue_pack),
        .in_mask   (issue_pack.b_mask),
        .resolve   (resolve),
        .out_valid (iss_valid),
        .out_data  (iss_data),
        .out_mask  (iss_mask)
    );

    // b_mask sits in the low bits, swap in the updated stage mask
    assign fu_in = {iss_data[$bits(issue_packet_t)-1:$bits(br_mask_t)], iss_mask};

    branch_fu u_branch_fu (
        .clock        (clock),
        .arst_n       (arst_n),
        .in_valid     (iss_valid),
        .is_pack      (fu_in),
        .result_valid (result_valid),
        .result       (result),
        .resolve      (resolve)
    );

    branch_tag_tracker u_tag_tracker (
        .clock       (clock),
        .arst_n      (arst_n),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_id    (alloc_id),
        .alloc_mask  (alloc_mask),
        .resolve     (resolve),
        .live_mask   (live_mask)
    );

endmodule

`default_nettype wire

/* src/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and address width
`define XLEN 32

// Branch tags in flight, also the width of every branch mask
`define BR_TAGS 4

`endif

/* src/core_pkg.sv */
`default_nettype none

`include "core_macros.svh"

package core_pkg;

    // One-hot tag or dependency mask
    typedef logic [`BR_TAGS-1:0] br_mask_t;

    typedef enum logic [1:0] {
        NOTHING = 2'd0,
        CLEAR   = 2'd1,  // Prediction was right
        SQUASH  = 2'd2   // Mispredict, kill dependents
    } br_task_e;

    typedef struct packed {
        br_task_e br_task;
        br_mask_t id;
    } br_resolve_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        isa_pkg::inst_t   inst;
        logic [`XLEN-1:0] rs1_value;
        logic [`XLEN-1:0] rs2_value;
        logic             pred_taken;
        logic [`XLEN-1:0] pred_target;
        logic [4:0]       rd;
        br_mask_t         b_id;
        br_mask_t         b_mask;  // Kept last, the top relies on it
    } issue_packet_t;

    typedef struct packed {
        logic [`XLEN-1:0] next_pc;
        logic [`XLEN-1:0] link;
        logic [4:0]       rd;
        logic             taken;
        logic             pred_correct;
        br_mask_t         b_id;
        br_mask_t         b_mask;  // Kept last
    } fu_packet_t;

endpackage

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef enum logic [6:0] {
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } br_funct3_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        br_funct3_e funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
    } b_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_type_t;

    // One 32-bit word, viewed through any format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        j_type_t j;
    } inst_t;

endpackage

`default_nettype wire

/* src/spec_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module spec_stage #(
    parameter type payload_t = logic
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  in_valid,
    output logic                  in_ready,
    input  payload_t              in_data,
    input  core_pkg::br_mask_t    in_mask,
    input  core_pkg::br_resolve_t resolve,
    output logic                  out_valid,
    output payload_t              out_data,
    output core_pkg::br_mask_t    out_mask
);
    import core_pkg::*;

    logic     ready_q;
    logic     valid_q;
    payload_t data_q;
    br_mask_t mask_q;
    br_mask_t clr_bits;
    logic     kill_in;
    logic     kill_held;
    logic     valid_n;
    payload_t data_n;
    br_mask_t mask_n;

    assign clr_bits  = (resolve.br_task == CLEAR) ? resolve.id : '0;
    assign kill_in   = (resolve.br_task == SQUASH) && ((in_mask & resolve.id) != '0);
    assign kill_held = (resolve.br_task == SQUASH) && ((mask_q & resolve.id) != '0);

    always_comb begin
        if (ready_q) begin
            valid_n = in_valid && !kill_in;  // Incoming entry replaces held one
            data_n  = in_data;
            mask_n  = in_mask & ~clr_bits;
        end else begin
            valid_n = valid_q && !kill_held;  // Hold, first cycle out of reset
            data_n  = data_q;
            mask_n  = mask_q & ~clr_bits;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            ready_q <= 1'b0;
            valid_q <= 1'b0;
            mask_q  <= '0;
        end else begin
            ready_q <= 1'b1;
            valid_q <= valid_n;
            mask_q  <= mask_n;
        end
    end

    always_ff @(posedge clock) begin
        data_q <= data_n;
    end

    assign in_ready  = ready_q;
    assign out_valid = valid_q;
    assign out_data  = data_q;
    assign out_mask  = mask_q;

    // A cleared tag must be gone from the mask one cycle later
    a_clear_applied: assert property (@(posedge clock) disable iff (!arst_n)
        resolve.br_task == CLEAR |=> (out_mask & $past(resolve.id)) == '0)
        else $error("spec_stage: cleared tag still in mask");

endmodule

`default_nettype wire

/* testbench/tb_branch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_macros.svh"

module tb_branch_unit;
    import isa_pkg::*;
    import core_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;  // About 25 branches of under 10 cycles, plus reset

    logic          clock;
    logic          arst_n;
    logic          issue_valid;
    logic          issue_ready;
    issue_packet_t issue_pack;
    logic          alloc_valid;
    logic          alloc_ready;
    br_mask_t      alloc_id;
    br_mask_t      alloc_mask;
    br_mask_t      live_mask;
    logic          result_valid;
    fu_packet_t    result;
    br_resolve_t   resolve;

    logic [31:0] lfsr_state;
    int          cycle_count;
    br_mask_t    model_live;  // Tags the testbench believes are in flight
    br_mask_t    model_dep [`BR_TAGS];

    branch_unit_top i_dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_pack   (issue_pack),
        .alloc_valid  (alloc_valid),
        .alloc_ready  (alloc_ready),
        .alloc_id     (alloc_id),
        .alloc_mask   (alloc_mask),
        .live_mask    (live_mask),
        .result_valid (result_valid),
        .result       (result),
        .resolve      (resolve)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value      = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic logic [31:0] encode_branch(br_funct3_e f3, logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] encode_jal(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    function automatic logic [31:0] encode_jalr(logic [11:0] imm, logic [4:0] rd);
        return {imm, 5'd1, 3'b000, rd, OP_JALR};
    endfunction

    // Reference outcome straight from the RISC-V branch and jump rules
    function automatic fu_packet_t expected_result(issue_packet_t p);
        fu_packet_t              r;
        logic [31:0]             w;
        logic [`XLEN-1:0]        target;
        logic signed [`XLEN-1:0] a;
        logic signed [`XLEN-1:0] b;
        logic                    taken;
        w      = p.inst;
        a      = p.rs1_value;
        b      = p.rs2_value;
        target = p.pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        case (w[14:12])
            BEQ:     taken = a == b;
            BNE:     taken = a != b;
            BLT:     taken = a < b;
            BGE:     taken = a >= b;
            BLTU:    taken = p.rs1_value < p.rs2_value;
            BGEU:    taken = p.rs1_value >= p.rs2_value;
            default: taken = 1'b0;
        endcase
        if (w[6:0] == OP_JAL) begin
            taken  = 1'b1;
            target = p.pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        end else if (w[6:0] == OP_JALR) begin
            taken  = 1'b1;
            target = (p.rs1_value + {{20{w[31]}}, w[31:20]}) & ~`XLEN'd1;
        end
        r.link         = p.pc + `XLEN'd4;
        r.next_pc      = taken ? target : r.link;
        r.rd           = p.rd;
        r.taken        = taken;
        r.pred_correct = (p.pred_taken == taken) && (!taken || p.pred_target == target);
        r.b_id         = p.b_id;
        r.b_mask       = p.b_mask;
        return r;
    endfunction

    // Builds a packet whose prediction is right
    function automatic issue_packet_t make_packet(logic [31:0] word, logic [`XLEN-1:0] rs1,
                                                  logic [`XLEN-1:0] rs2, br_mask_t tag,
                                                  br_mask_t deps);
        issue_packet_t p;
        fu_packet_t    r;
        logic [31:0]   rnd;
        p           = '0;
        rnd         = random_bits(30);
        p.pc        = {rnd[29:0], 2'b00};
        rnd         = random_bits(5);
        p.rd        = rnd[4:0];
        p.inst      = word;
        p.rs1_value = rs1;
        p.rs2_value = rs2;
        p.b_id      = tag;
        p.b_mask    = deps;
        r             = expected_result(p);
        p.pred_taken  = r.taken;
        p.pred_target = r.next_pc;
        return p;
    endfunction

    function automatic logic [12:0] random_offset();
        logic [31:0] rnd;
        rnd = random_bits(12);
        return {rnd[11:0], 1'b0};
    endfunction

    task automatic check_fu_packet(string name, fu_packet_t expected, fu_packet_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_resolve(string name, br_resolve_t expected, br_resolve_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_mask(string name, br_mask_t expected, br_mask_t actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s: expected %b actual %b", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic model_resolve(br_resolve_t r);
        br_mask_t freed;
        freed = r.id;
        for (int t = 0; t < `BR_TAGS; t++) begin
            if (r.br_task == SQUASH && model_live[t] && (model_dep[t] & r.id) != '0) begin
                freed[t] = 1'b1;  // Depends on the mispredicted branch
            end
        end
        model_live = model_live & ~freed;
        for (int t = 0; t < `BR_TAGS; t++) begin
            model_dep[t] = model_dep[t] & ~freed;
        end
    endtask

    // All drive tasks start and end 2 ns after a rising edge
    task automatic allocate_tag(string name, output br_mask_t tag, output br_mask_t deps);
        br_mask_t want_id;
        want_id = '0;
        for (int t = 0; t < `BR_TAGS; t++) begin
            if (!model_live[t]) begin
                want_id[t] = 1'b1;
                break;
            end
        end
        alloc_valid = 1'b1;
        @(negedge clock);
        check_bit({name, " alloc_ready"}, 1'b1, alloc_ready);
        check_mask({name, " alloc_id"}, want_id, alloc_id);
        check_mask({name, " alloc_mask"}, model_live, alloc_mask);
        tag  = alloc_id;
        deps = alloc_mask;
        @(posedge clock);
        #2;
        alloc_valid = 1'b0;
        model_live  = model_live | tag;
        for (int t = 0; t < `BR_TAGS; t++) begin
            if (tag[t]) model_dep[t] = deps;
        end
    endtask

    task automatic issue_branch(issue_packet_t p);
        issue_valid = 1'b1;
        issue_pack  = p;
        @(negedge clock);
        while (!issue_ready) @(negedge clock);
        @(posedge clock);
        #2;
        issue_valid = 1'b0;
    endtask

    task automatic wait_result(output fu_packet_t res, output br_resolve_t rsv);
        @(negedge clock);
        while (!result_valid) @(negedge clock);
        res = result;
        rsv = resolve;
        @(posedge clock);
        #2;
    endtask

    task automatic expect_no_result(string name, int cycles);
        repeat (cycles) begin
            @(negedge clock);
            check_bit({name, " result_valid"}, 1'b0, result_valid);
            if (resolve.br_task != NOTHING) begin
                $display("%s: resolve broadcast seen without a result", name);
                abort_run();
            end
        end
        @(posedge clock);
        #2;
    endtask

    task automatic check_outcome(string name, issue_packet_t p, fu_packet_t exp);
        fu_packet_t  got;
        br_resolve_t got_rsv;
        br_resolve_t exp_rsv;
        exp_rsv.br_task = exp.pred_correct ? CLEAR : SQUASH;
        exp_rsv.id      = p.b_id;
        wait_result(got, got_rsv);
        check_fu_packet(name, exp, got);
        check_resolve(name, exp_rsv, got_rsv);
        model_resolve(exp_rsv);
        check_mask({name, " live_mask"}, model_live, live_mask);
    endtask

    task automatic run_one(string name, issue_packet_t p);
        issue_branch(p);
        check_outcome(name, p, expected_result(p));
    endtask

    task automatic test_conditional_branches();
        br_funct3_e    codes [6];
        br_mask_t      tag;
        br_mask_t      deps;
        logic [31:0]   a;
        logic [31:0]   b;
        issue_packet_t p;
        codes = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        for (int c = 0; c < 6; c++) begin
            for (int eq = 0; eq < 2; eq++) begin
                a = random_bits(32);
                b = eq ? a : random_bits(32);
                allocate_tag("cond alloc", tag, deps);
                p = make_packet(encode_branch(codes[c], random_offset()), a, b, tag, deps);
                run_one($sformatf("cond_%s_%s", codes[c].name(), eq ? "equal" : "random"), p);
            end
        end
    endtask

    task automatic test_mispredicts();
        br_mask_t      tag;
        br_mask_t      deps;
        logic [31:0]   a;
        issue_packet_t p;
        a = random_bits(32);
        allocate_tag("mispredict alloc", tag, deps);
        p = make_packet(encode_branch(BEQ, random_offset()), a, a, tag, deps);
        p.pred_taken = 1'b0;  // Taken, predicted not taken
        run_one("mispredict_dir_taken", p);
        allocate_tag("mispredict alloc", tag, deps);
        p = make_packet(encode_branch(BNE, random_offset()), a, a, tag, deps);
        p.pred_taken = 1'b1;
        run_one("mispredict_dir_not_taken", p);
        a = random_bits(31);
        allocate_tag("mispredict alloc", tag, deps);
        p = make_packet(encode_branch(BLTU, random_offset()), a, a | 32'h8000_0000, tag, deps);
        p.pred_target = p.pred_target + 32'd16;  // Right direction, wrong target
        run_one("mispredict_target", p);
    endtask

    task automatic test_jumps();
        br_mask_t      tag;
        br_mask_t      deps;
        logic [31:0]   rnd;
        logic [31:0]   base;
        issue_packet_t p;
        rnd = random_bits(20);
        allocate_tag("jump alloc", tag, deps);
        p = make_packet(encode_jal({rnd[19:0], 1'b0}, 5'd1), random_bits(32), '0, tag, deps);
        run_one("jal", p);
        base = random_bits(32) | 32'h1;  // Odd sum, bit 0 must drop
        rnd  = random_bits(11);
        allocate_tag("jump alloc", tag, deps);
        p = make_packet(encode_jalr({rnd[10:0], 1'b0}, 5'd5), base, '0, tag, deps);
        run_one("jalr", p);
        rnd = random_bits(20);
        allocate_tag("jump alloc", tag, deps);
        p = make_packet(encode_jal({rnd[19:0], 1'b0}, 5'd1), '0, '0, tag, deps);
        p.pred_taken = 1'b0;
        run_one("jal_predicted_not_taken", p);
    endtask

    task automatic run_dependent_pair(string name, logic older_correct);
        br_mask_t      old_tag;
        br_mask_t      old_deps;
        br_mask_t      young_tag;
        br_mask_t      young_deps;
        logic [31:0]   a;
        issue_packet_t older;
        issue_packet_t younger;
        fu_packet_t    exp_young;
        a = random_bits(32);
        allocate_tag({name, " alloc"}, old_tag, old_deps);
        allocate_tag({name, " alloc"}, young_tag, young_deps);
        older = make_packet(encode_branch(BNE, random_offset()), a, ~a, old_tag, old_deps);
        if (!older_correct) older.pred_taken = 1'b0;
        younger = make_packet(encode_branch(BGEU, random_offset()), random_bits(32),
                              random_bits(32), young_tag, young_deps);
        exp_young        = expected_result(younger);
        exp_young.b_mask = young_deps & ~old_tag;  // Older bit gone after its CLEAR
        issue_branch(older);
        issue_branch(younger);
        check_outcome({name, "_older"}, older, expected_result(older));
        if (older_correct) begin
            check_outcome({name, "_younger"}, younger, exp_young);
        end else begin
            expect_no_result({name, "_younger"}, 4);
        end
        check_mask({name, " live_mask"}, '0, live_mask);
    endtask

    task automatic test_tag_pool();
        br_mask_t      tags [`BR_TAGS];
        br_mask_t      deps;
        logic [31:0]   a;
        issue_packet_t p;
        for (int i = 0; i < `BR_TAGS; i++) begin
            allocate_tag("pool alloc", tags[i], deps);
        end
        @(negedge clock);
        check_bit("pool_full alloc_ready", 1'b0, alloc_ready);
        check_mask("pool_full live_mask", 4'b1111, live_mask);
        @(posedge clock);
        #2;
        a = random_bits(32);
        p = make_packet(encode_branch(BEQ, random_offset()), a, a, tags[1], model_dep[1]);
        run_one("pool_clear", p);
        check_mask("pool_clear live_mask", 4'b1101, live_mask);
        check_bit("pool_clear alloc_ready", 1'b1, alloc_ready);
        p = make_packet(encode_branch(BNE, random_offset()), a, a, tags[2], model_dep[2]);
        p.pred_taken = 1'b1;
        run_one("pool_squash", p);
        check_mask("pool_squash live_mask", 4'b0001, live_mask);
        p = make_packet(encode_branch(BLT, random_offset()), a, a, tags[0], model_dep[0]);
        run_one("pool_drain", p);
        check_mask("pool_drain live_mask", 4'b0000, live_mask);
    endtask

    initial begin
        arst_n      = 1'b0;
        issue_valid = 1'b0;
        issue_pack  = '0;
        alloc_valid = 1'b0;
        lfsr_state  = 32'h5811;
        cycle_count = 0;
        model_live  = '0;
        for (int t = 0; t < `BR_TAGS; t++) begin
            model_dep[t] = '0;
        end
        repeat (16) @(posedge clock);
        #2;
        check_bit("reset issue_ready", 1'b0, issue_ready);
        arst_n = 1'b1;
        @(negedge clock);
        check_bit("reset result_valid", 1'b0, result_valid);
        check_resolve("reset resolve", '{br_task: NOTHING, id: '0}, resolve);
        check_bit("reset alloc_ready", 1'b1, alloc_ready);
        check_mask("reset live_mask", '0, live_mask);
        @(posedge clock);
        #2;
        test_conditional_branches();
        test_mispredicts();
        test_jumps();
        run_dependent_pair("dep_squash", 1'b0);
        run_dependent_pair("dep_clear", 1'b1);
        test_tag_pool();
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire
